// File: verilog/dht11_pkg.sv
`default_nettype none

package dht11_pkg;

  //////////////////////////////////////////////////////////////////////
  // exchange sequence
  //////////////////////////////////////////////////////////////////////

  // one state per phase of the single-wire exchange
  typedef enum logic [2:0] {
    st_idle,
    st_start_low,
    st_wait_resp_low,
    st_wait_resp_high,
    st_wait_data,
    st_read_bits
  } exchange_state_e;

  // 22 bits covers three seconds of microseconds
  typedef logic [21:0] usec_count_t;

  //////////////////////////////////////////////////////////////////////
  // frame layout
  //////////////////////////////////////////////////////////////////////

  typedef logic [7:0] sensor_byte_t;

  // sensor sends humidity first, checksum last, msb first
  typedef struct packed {
    sensor_byte_t humidity_int;
    sensor_byte_t humidity_dec;
    sensor_byte_t temperature_int;
    sensor_byte_t temperature_dec;
    sensor_byte_t checksum;
  } sensor_frame_t;

  localparam int unsigned FRAME_BITS = 40;

  // default timing, 100 MHz clock
  localparam int unsigned DEF_CLKS_PER_USEC = 100;
  localparam int unsigned DEF_IDLE_USEC = 3_000_000;
  localparam int unsigned DEF_START_LOW_USEC = 20_000;
  localparam int unsigned DEF_TIMEOUT_USEC = 100_000;
  // high pulse of 26-28 us is a zero, 70 us is a one
  localparam int unsigned DEF_ONE_MIN_USEC = 50;

endpackage

`default_nettype wire

// File: verilog/sensor_link_if.sv
`timescale 1ns/1ps
`default_nettype none

interface sensor_link_if (
  input logic clk
);

  // synchronized copy of the data line
  logic line_level;
  // single-cycle edge strobes
  logic line_rise;
  logic line_fall;
  // single-cycle strobe, once per microsecond
  logic usec_tick;

  // driven by the line monitor only
  modport source (
    input  clk,
    output line_level,
    output line_rise,
    output line_fall,
    output usec_tick
  );

  // fsm and bit decoder only look
  modport sink (
    input clk,
    input line_level,
    input line_rise,
    input line_fall,
    input usec_tick
  );

endinterface

`default_nettype wire

// File: verilog/line_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module line_monitor #(
  parameter int unsigned CLKS_PER_USEC = dht11_pkg::DEF_CLKS_PER_USEC
) (
  input logic         clk,
  input logic         reset_p,
  input logic         line_in,
  sensor_link_if.source link
);

  // divider width, at least one bit
  localparam int DIV_W = (CLKS_PER_USEC > 1) ? $clog2(CLKS_PER_USEC) : 1;
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(CLKS_PER_USEC - 1);

  logic [1:0]       sync_q;
  logic             level_q;
  logic [DIV_W-1:0] div_cnt;

  //////////////////////////////////////////////////////////////////////
  // line conditioning
  //////////////////////////////////////////////////////////////////////

  // two-flop sync, then edge register
  // line rests high through the pull-up, so reset to one
  always_ff @(posedge clk or posedge reset_p) begin
    if (reset_p) begin
      sync_q         <= 2'b11;
      level_q        <= 1'b1;
      link.line_rise <= 1'b0;
      link.line_fall <= 1'b0;
    end else begin
      sync_q         <= {sync_q[0], line_in};
      level_q        <= sync_q[1];
      // strobes line up with the new level
      link.line_rise <= sync_q[1] & ~level_q;
      link.line_fall <= ~sync_q[1] & level_q;
    end
  end

  assign link.line_level = level_q;

  //////////////////////////////////////////////////////////////////////
  // microsecond tick
  //////////////////////////////////////////////////////////////////////

  // free-running from reset
  always_ff @(posedge clk or posedge reset_p) begin
    if (reset_p) begin
      div_cnt        <= '0;
      link.usec_tick <= 1'b0;
    end else if (div_cnt == DIV_LAST) begin
      div_cnt        <= '0;
      link.usec_tick <= 1'b1;
    end else begin
      div_cnt        <= div_cnt + 1'b1;
      link.usec_tick <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: verilog/exchange_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module exchange_fsm #(
  parameter int unsigned IDLE_USEC      = dht11_pkg::DEF_IDLE_USEC,
  parameter int unsigned START_LOW_USEC = dht11_pkg::DEF_START_LOW_USEC,
  parameter int unsigned TIMEOUT_USEC   = dht11_pkg::DEF_TIMEOUT_USEC
) (
  input  logic        clk,
  input  logic        reset_p,
  sensor_link_if.sink link,
  input  logic        frame_done,
  output logic        drive_low,
  output logic        read_active
);

  import dht11_pkg::*;

  localparam usec_count_t IDLE_LIMIT    = usec_count_t'(IDLE_USEC);
  localparam usec_count_t START_LIMIT   = usec_count_t'(START_LOW_USEC);
  localparam usec_count_t TIMEOUT_LIMIT = usec_count_t'(TIMEOUT_USEC);

  exchange_state_e state_q;
  exchange_state_e state_d;
  usec_count_t     phase_cnt;
  logic            timed_out;
  logic            bit_edge;

  // any waiting phase gives up past the limit
  assign timed_out = (phase_cnt > TIMEOUT_LIMIT);

  // in the read phase the timeout runs per line edge,
  // a whole frame is far longer than one bit
  assign bit_edge = read_active & (link.line_rise | link.line_fall);

  //////////////////////////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (phase_cnt >= IDLE_LIMIT) state_d = st_start_low;
      end
      // host holds the line low, then lets go
      st_start_low: begin
        if (phase_cnt >= START_LIMIT) state_d = st_wait_resp_low;
      end
      // sensor answers low ...
      st_wait_resp_low: begin
        if (timed_out) state_d = st_idle;
        else if (link.line_fall) state_d = st_wait_resp_high;
      end
      // ... then high ...
      st_wait_resp_high: begin
        if (timed_out) state_d = st_idle;
        else if (link.line_rise) state_d = st_wait_data;
      end
      // ... then falls into the first bit
      st_wait_data: begin
        if (timed_out) state_d = st_idle;
        else if (link.line_fall) state_d = st_read_bits;
      end
      st_read_bits: begin
        if (timed_out || frame_done) state_d = st_idle;
      end
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk or posedge reset_p) begin
    if (reset_p) state_q <= st_idle;
    else state_q <= state_d;
  end

  //////////////////////////////////////////////////////////////////////
  // phase counter
  //////////////////////////////////////////////////////////////////////

  // restart on state change, count microseconds otherwise
  always_ff @(posedge clk or posedge reset_p) begin
    if (reset_p) begin
      phase_cnt <= '0;
    end else if ((state_d != state_q) || bit_edge) begin
      phase_cnt <= '0;
    end else if (link.usec_tick) begin
      phase_cnt <= phase_cnt + 1'b1;
    end
  end

  // outputs straight from state
  assign drive_low   = (state_q == st_start_low);
  assign read_active = (state_q == st_read_bits);

endmodule

`default_nettype wire

// File: verilog/bit_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module bit_decoder #(
  parameter int unsigned ONE_MIN_USEC = dht11_pkg::DEF_ONE_MIN_USEC
) (
  input  logic                    clk,
  input  logic                    reset_p,
  sensor_link_if.sink             link,
  input  logic                    read_active,
  output logic                    frame_done,
  output dht11_pkg::sensor_frame_t frame
);

  import dht11_pkg::*;

  localparam int BIT_CNT_W = $clog2(FRAME_BITS + 1);
  localparam logic [BIT_CNT_W-1:0] LAST_BIT = BIT_CNT_W'(FRAME_BITS - 1);
  localparam usec_count_t ONE_LIMIT = usec_count_t'(ONE_MIN_USEC);

  logic                  high_phase;
  usec_count_t           high_cnt;
  logic [BIT_CNT_W-1:0]  bit_cnt;
  logic [FRAME_BITS-1:0] shift_q;
  logic                  bit_value;

  // long high pulse reads as one
  assign bit_value = (high_cnt >= ONE_LIMIT);

  //////////////////////////////////////////////////////////////////////
  // pulse measurement and shift
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge reset_p) begin
    if (reset_p) begin
      high_phase <= 1'b0;
      high_cnt   <= '0;
      bit_cnt    <= '0;
      shift_q    <= '0;
      frame_done <= 1'b0;
    end else if (!read_active) begin
      // outside the read phase, hold everything cleared
      high_phase <= 1'b0;
      high_cnt   <= '0;
      bit_cnt    <= '0;
      shift_q    <= '0;
      frame_done <= 1'b0;
    end else begin
      frame_done <= 1'b0;
      if (link.line_rise) begin
        // start of a data pulse
        high_phase <= 1'b1;
        high_cnt   <= '0;
      end else if (high_phase && link.line_fall) begin
        // pulse over, msb first
        shift_q    <= {shift_q[FRAME_BITS-2:0], bit_value};
        high_phase <= 1'b0;
        high_cnt   <= '0;
        if (bit_cnt == LAST_BIT) begin
          bit_cnt    <= '0;
          frame_done <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end else if (high_phase && link.line_level && link.usec_tick) begin
        high_cnt <= high_cnt + 1'b1;
      end
    end
  end

  // valid while frame_done is high, cleared once read phase ends
  assign frame = sensor_frame_t'(shift_q);

endmodule

`default_nettype wire

// File: verilog/frame_checker.sv
`timescale 1ns/1ps
`default_nettype none

module frame_checker (
  input  logic                     clk,
  input  logic                     reset_p,
  input  logic                     frame_done,
  input  dht11_pkg::sensor_frame_t frame,
  output dht11_pkg::sensor_byte_t  humidity,
  output dht11_pkg::sensor_byte_t  temperature
);

  import dht11_pkg::*;

  sensor_byte_t byte_sum;
  logic         sum_ok;

  //////////////////////////////////////////////////////////////////////
  // checksum
  //////////////////////////////////////////////////////////////////////

  // plain 8-bit sum, carries drop off
  assign byte_sum = frame.humidity_int + frame.humidity_dec
                  + frame.temperature_int + frame.temperature_dec;
  assign sum_ok = (byte_sum == frame.checksum);

  // only integer parts are kept, dht11 decimals are zero anyway
  // bad frame leaves last good reading
  always_ff @(posedge clk or posedge reset_p) begin
    if (reset_p) begin
      humidity    <= '0;
      temperature <= '0;
    end else if (frame_done && sum_ok) begin
      humidity    <= frame.humidity_int;
      temperature <= frame.temperature_int;
    end
  end

endmodule

`default_nettype wire

// File: verilog/dht11_reader.sv
`timescale 1ns/1ps
`default_nettype none

module dht11_reader #(
  parameter int unsigned CLKS_PER_USEC  = dht11_pkg::DEF_CLKS_PER_USEC,
  parameter int unsigned IDLE_USEC      = dht11_pkg::DEF_IDLE_USEC,
  parameter int unsigned START_LOW_USEC = dht11_pkg::DEF_START_LOW_USEC,
  parameter int unsigned TIMEOUT_USEC   = dht11_pkg::DEF_TIMEOUT_USEC,
  parameter int unsigned ONE_MIN_USEC   = dht11_pkg::DEF_ONE_MIN_USEC
) (
  input  logic       clk,
  input  logic       reset_p,
  inout  wire        dht11_data,
  output logic [7:0] humidity,
  output logic [7:0] temperature
);

  import dht11_pkg::*;

  logic          drive_low;
  logic          read_active;
  logic          frame_done;
  sensor_frame_t frame;

  sensor_link_if link_if (.clk(clk));

  //////////////////////////////////////////////////////////////////////
  // open-drain pad, needs external pull-up
  //////////////////////////////////////////////////////////////////////

  assign dht11_data = drive_low ? 1'b0 : 1'bz;

  // pin in, edges and tick out
  line_monitor #(
    .CLKS_PER_USEC(CLKS_PER_USEC)
  ) line_monitor_i (
    .clk    (clk),
    .reset_p(reset_p),
    .line_in(dht11_data),
    .link   (link_if.source)
  );

  exchange_fsm #(
    .IDLE_USEC     (IDLE_USEC),
    .START_LOW_USEC(START_LOW_USEC),
    .TIMEOUT_USEC  (TIMEOUT_USEC)
  ) exchange_fsm_i (
    .clk        (clk),
    .reset_p    (reset_p),
    .link       (link_if.sink),
    .frame_done (frame_done),
    .drive_low  (drive_low),
    .read_active(read_active)
  );

  bit_decoder #(
    .ONE_MIN_USEC(ONE_MIN_USEC)
  ) bit_decoder_i (
    .clk        (clk),
    .reset_p    (reset_p),
    .link       (link_if.sink),
    .read_active(read_active),
    .frame_done (frame_done),
    .frame      (frame)
  );

  frame_checker frame_checker_i (
    .clk        (clk),
    .reset_p    (reset_p),
    .frame_done (frame_done),
    .frame      (frame),
    .humidity   (humidity),
    .temperature(temperature)
  );

endmodule

`default_nettype wire

// File: verif/dht11_reader_sva.sv
`timescale 1ns/1ps
`default_nettype none

module dht11_reader_sva (
  input logic                       clk,
  input logic                       reset_p,
  input dht11_pkg::exchange_state_e state,
  input logic                       frame_done,
  input logic                       drive_low,
  input logic                       read_active
);

  import dht11_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // phase order around the line driver and the read phase
  //////////////////////////////////////////////////////////////////////

  // start pulse only ever begins out of idle
  start_from_idle: assert property (
    @(posedge clk) disable iff (reset_p)
    $rose(drive_low) |-> ($past(state) == st_idle)
  ) else $error("start pulse began outside st_idle");

  // releasing the line hands over to the sensor response
  start_to_resp: assert property (
    @(posedge clk) disable iff (reset_p)
    $fell(drive_low) |-> (state == st_wait_resp_low)
  ) else $error("start pulse did not end in st_wait_resp_low");

  // decoder enabled only after the full sensor response
  read_from_wait_data: assert property (
    @(posedge clk) disable iff (reset_p)
    $rose(read_active) |-> ($past(state) == st_wait_data)
  ) else $error("read phase entered outside st_wait_data");

  // finished frame ends the read phase
  frame_ends_read: assert property (
    @(posedge clk) disable iff (reset_p)
    (read_active && frame_done) |=> (state == st_idle)
  ) else $error("read phase not left after frame_done");

endmodule

bind exchange_fsm dht11_reader_sva sva_i (
  .clk        (clk),
  .reset_p    (reset_p),
  .state      (state_q),
  .frame_done (frame_done),
  .drive_low  (drive_low),
  .read_active(read_active)
);

`default_nettype wire

// File: verif/dht11_reader_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dht11_reader_tb;

  import dht11_pkg::*;

  // one exchange takes a few ms with these values
  localparam int unsigned CLKS_PER_USEC  = 2;
  localparam int unsigned IDLE_USEC      = 1000;
  localparam int unsigned START_LOW_USEC = 200;
  localparam int unsigned TIMEOUT_USEC   = 1000;
  localparam int unsigned ONE_MIN_USEC   = 50;
  localparam int unsigned NUM_ROWS       = 8;
  // at most 8 ms per row plus reset margin
  localparam int unsigned CYCLE_LIMIT    = NUM_ROWS * 8000 * CLKS_PER_USEC + 10000;

  typedef struct packed {
    sensor_byte_t hum_int;
    sensor_byte_t hum_dec;
    sensor_byte_t temp_int;
    sensor_byte_t temp_dec;
    logic         corrupt;
    logic         silent;
  } stim_row_t;

  logic         clk;
  logic         reset_p;
  logic         sensor_low;
  wire          dht11_data;
  sensor_byte_t humidity;
  sensor_byte_t temperature;
  int unsigned  cycle_cnt;
  stim_row_t    stim_table [NUM_ROWS];
  string        row_name [NUM_ROWS];

  // open-drain line pulled up when released
  pullup (dht11_data);
  assign dht11_data = sensor_low ? 1'b0 : 1'bz;

  dht11_reader #(
    .CLKS_PER_USEC (CLKS_PER_USEC),
    .IDLE_USEC     (IDLE_USEC),
    .START_LOW_USEC(START_LOW_USEC),
    .TIMEOUT_USEC  (TIMEOUT_USEC),
    .ONE_MIN_USEC  (ONE_MIN_USEC)
  ) dht11_reader_i (
    .clk        (clk),
    .reset_p    (reset_p),
    .dht11_data (dht11_data),
    .humidity   (humidity),
    .temperature(temperature)
  );

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  task automatic fail_run();
    $display("TEST FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic compare_byte(input string name, input string what,
                              input sensor_byte_t expected, input sensor_byte_t actual);
    if (actual !== expected) begin
      $display("error %s %s: expected 8'h%02h, actual 8'h%02h", name, what, expected, actual);
      fail_run();
    end
  endtask

  // tick counts may be off by the slack either way
  task automatic compare_ticks(input string name, input string what, input usec_count_t expected,
                               input usec_count_t actual, input usec_count_t slack);
    if ((actual + slack < expected) || (actual > expected + slack)) begin
      $display("error %s %s: expected %0d +/- %0d ticks, actual %0d ticks",
               name, what, expected, slack, actual);
      fail_run();
    end
  endtask

  // whole run bounded by a cycle count
  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d clock cycles", CYCLE_LIMIT);
    fail_run();
  end

  //////////////////////////////////////////////////////////////////////
  // sensor model
  //////////////////////////////////////////////////////////////////////

  task automatic wait_usec(input int unsigned usec);
    repeat (usec * CLKS_PER_USEC) @(posedge clk);
  endtask

  // 50 us low, then 26 us high for zero or 70 us for one
  task automatic send_bit(input logic value);
    sensor_low <= 1'b1;
    wait_usec(50);
    sensor_low <= 1'b0;
    wait_usec(value ? 70 : 26);
  endtask

  task automatic send_byte(input sensor_byte_t value);
    for (int i = 7; i >= 0; i--) send_bit(value[i]);
  endtask

  // response, 40 bits, then the closing low is left driven
  task automatic send_frame(input stim_row_t row, input sensor_byte_t checksum);
    wait_usec(20);
    sensor_low <= 1'b1;
    wait_usec(80);
    sensor_low <= 1'b0;
    wait_usec(80);
    send_byte(row.hum_int);
    send_byte(row.hum_dec);
    send_byte(row.temp_int);
    send_byte(row.temp_dec);
    send_byte(checksum);
    sensor_low <= 1'b1;
  endtask

  // line sampled between rising edges
  // returns once the start pulse is seen released
  task automatic await_start(input string name, input logic check_idle);
    int unsigned high_cycles;
    int unsigned low_cycles;
    high_cycles = 0;
    low_cycles  = 0;
    do begin
      @(negedge clk);
      high_cycles++;
    end while (dht11_data !== 1'b0);
    // idle counted from reset release and at most one tick late
    if (check_idle)
      compare_ticks(name, "idle time", usec_count_t'(IDLE_USEC),
                    usec_count_t'((high_cycles - 1) / CLKS_PER_USEC), 22'd1);
    do begin
      @(negedge clk);
      low_cycles++;
    end while (dht11_data === 1'b0);
    compare_ticks(name, "start pulse", usec_count_t'(START_LOW_USEC),
                  usec_count_t'(low_cycles / CLKS_PER_USEC), 22'd1);
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus table
  //////////////////////////////////////////////////////////////////////

  function automatic sensor_byte_t random_byte();
    return sensor_byte_t'($urandom());
  endfunction

  task automatic set_row(input int idx, input string name,
                         input sensor_byte_t h, hd, t, td, input logic corrupt, silent);
    row_name[idx]   = name;
    stim_table[idx] = '{h, hd, t, td, corrupt, silent};
  endtask

  task automatic load_table();
    // name, humidity, hum dec, temperature, temp dec, corrupt, silent
    set_row(0, "basic",        8'd45, 8'd0,  8'd23, 8'd0,  1'b0, 1'b0);
    set_row(1, "bad_checksum", 8'd60, 8'd0,  8'd30, 8'd0,  1'b1, 1'b0);
    set_row(2, "silent",       8'd0,  8'd0,  8'd0,  8'd0,  1'b0, 1'b1);
    set_row(3, "all_zero",     8'h00, 8'h00, 8'h00, 8'h00, 1'b0, 1'b0);
    set_row(4, "all_ones",     8'hff, 8'hff, 8'hff, 8'hff, 1'b0, 1'b0);
    for (int i = 5; i < NUM_ROWS; i++)
      set_row(i, $sformatf("random_%0d", i - 5), random_byte(), random_byte(),
              random_byte(), random_byte(), 1'b0, 1'b0);
  endtask

  initial begin : main_sequence
    sensor_byte_t exp_humidity;
    sensor_byte_t exp_temperature;
    sensor_byte_t byte_sum;
    sensor_byte_t checksum;
    stim_row_t    row;
    reset_p         = 1'b1;
    sensor_low      = 1'b0;
    exp_humidity    = '0;
    exp_temperature = '0;
    void'($urandom(32'hdafa));
    load_table();
    repeat (5) @(posedge clk);
    compare_byte("reset", "humidity", 8'h00, humidity);
    compare_byte("reset", "temperature", 8'h00, temperature);
    reset_p <= 1'b0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      row = stim_table[r];
      await_start(row_name[r], r == 0);
      if (row.silent) begin
        // no answer so the reader times out and goes idle
        wait_usec(TIMEOUT_USEC + 100);
      end else begin
        byte_sum = row.hum_int + row.hum_dec + row.temp_int + row.temp_dec;
        checksum = row.corrupt ? (byte_sum ^ 8'h01) : byte_sum;
        // frame kept only when checksum is the byte sum
        if (checksum == byte_sum) begin
          exp_humidity    = row.hum_int;
          exp_temperature = row.temp_int;
        end
        send_frame(row, checksum);
        // five cycles after the last falling edge
        repeat (5) @(posedge clk);
      end
      @(negedge clk);
      compare_byte(row_name[r], "humidity", exp_humidity, humidity);
      compare_byte(row_name[r], "temperature", exp_temperature, temperature);
      if (!row.silent) begin
        // rest of the closing 50 us low, then release
        repeat (50 * CLKS_PER_USEC - 5) @(posedge clk);
        sensor_low <= 1'b0;
      end
    end
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
verilog/dht11_pkg.sv
verilog/sensor_link_if.sv
verilog/line_monitor.sv
verilog/exchange_fsm.sv
verilog/bit_decoder.sv
verilog/frame_checker.sv
verilog/dht11_reader.sv
verif/dht11_reader_sva.sv
verif/dht11_reader_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the dht11 reader testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module dht11_reader_tb \
  -f all.f
./obj_dir/Vdht11_reader_tb 2>&1 | tee sim.log

if grep -q "TEST PASSED" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
